//--- verilog/llq_pkg.sv
// Shared sizes, scalar types and packed structs of the linked-list queue controller
// Command, queue state and lookup record layouts
`default_nettype none

package llq_pkg;

  // Sizes
  localparam int NUM_CTXT  = 8;    // Number of queues
  localparam int NUM_ENTRY = 32;   // Shared entry pool
  localparam int DATA_W    = 16;   // Command payload width

  // Derived widths
  localparam int CTXT_W = $clog2(NUM_CTXT);
  localparam int ADDR_W = $clog2(NUM_ENTRY);

  // Scalars
  typedef logic [CTXT_W-1:0]   ctxt_t;     // Context number
  typedef logic [ADDR_W-1:0]   addr_t;     // Entry address
  typedef logic [DATA_W-1:0]   data_t;     // Payload
  typedef logic [NUM_CTXT-1:0] ctxt_vec_t; // One bit per context

  // State of one queue
  // head is the oldest entry, tail the newest
  typedef struct packed {
    logic  empty;  // No entries, head/tail meaningless
    addr_t head;
    addr_t tail;
  } queue_state_t;

  // Command from the source
  typedef struct packed {
    logic  push;   // 1 push, 0 pop
    ctxt_t ctxt;
    data_t data;   // Ignored on pop
  } cmd_t;

  // Lookup record, one per command
  // Names the storage location to write (push) or read (pop)
  typedef struct packed {
    logic  rnw;          // 1 for pop
    addr_t addr;
    data_t data;         // Zero on pop
    logic  empty_fault;  // Pop of an empty queue
  } lkup_t;

endpackage

`default_nettype wire

//--- verilog/sync_ram.sv
// Simple dual-port RAM, one synchronous read port and one write port
// Payload type given by parameter
`default_nettype none

module sync_ram #(
  parameter type payload_t = logic,
  parameter int  DEPTH     = 2
) (
  input  logic                     clk,
  input  logic                     rd_en,
  input  logic [$clog2(DEPTH)-1:0] rd_addr,
  input  logic                     wr_en,
  input  logic [$clog2(DEPTH)-1:0] wr_addr,
  input  payload_t                 wr_data,
  output payload_t                 rd_data
);

  payload_t mem [DEPTH];  // Storage array, no reset

  // Write port
  always_ff @(posedge clk)
  begin
    if (wr_en)
      mem[wr_addr] <= wr_data;
  end

  // Read port, data one edge after rd_en
  always_ff @(posedge clk)
  begin
    if (rd_en)
      rd_data <= mem[rd_addr];  // Holds last value when idle
  end

  // Hazard stall upstream keeps read and write apart
  // Same address in one cycle would give old data
  a_no_rw_collision : assert property (@(posedge clk)
    !(rd_en && wr_en && (rd_addr == wr_addr)))
    else $error("sync_ram: read and write to same address");

endmodule

`default_nettype wire

//--- verilog/llq_free_pool.sv
// Entry allocation bitset of the shared pool
// Lowest-free search and registered full flag
`default_nettype none

module llq_free_pool (
  input  logic           clk,
  input  logic           rst,
  input  logic           alloc,         // Take alloc_addr this edge
  input  logic           release_en,    // Give back release_addr this edge
  input  llq_pkg::addr_t release_addr,
  output llq_pkg::addr_t alloc_addr,    // Lowest free entry
  output logic           full
);

  logic [llq_pkg::NUM_ENTRY-1:0] used_q;  // 1 = entry allocated
  logic [llq_pkg::NUM_ENTRY-1:0] used_d;

  // Lowest free entry
  // Scan from the top so the lowest index wins
  always_comb
  begin
    alloc_addr = '0;
    for (int i = llq_pkg::NUM_ENTRY - 1; i >= 0; i--)
    begin
      if (!used_q[i])
        alloc_addr = llq_pkg::addr_t'(i);
    end
  end

  // Next bitset
  always_comb
  begin
    used_d = used_q;
    if (alloc)
      used_d[alloc_addr] = 1'b1;    // Mark new entry
    if (release_en)
      used_d[release_addr] = 1'b0;  // Popped entry back to pool
  end

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      used_q <= '0;  // All free
      full   <= 1'b0;
    end
    else
    begin
      used_q <= used_d;
      full   <= &used_d;  // Registered, no free entry left
    end
  end

  // Pipeline must hold pushes while full
  a_no_alloc_when_full : assert property (@(posedge clk) disable iff (rst)
    alloc |-> !full)
    else $error("llq_free_pool: alloc while full");

  // Only live entries come back
  a_release_allocated : assert property (@(posedge clk) disable iff (rst)
    release_en |-> used_q[release_addr])
    else $error("llq_free_pool: release of free entry");

endmodule

`default_nettype wire

//--- verilog/llq_state_table.sv
// Per-context queue state RAM with reset-init sequencer
// Write port shared between sequencer and pipeline
`default_nettype none

module llq_state_table (
  input  logic                  clk,
  input  logic                  rst,
  input  logic                  rd_en,
  input  llq_pkg::ctxt_t        rd_ctxt,
  input  logic                  wr_en,      // From pipeline when not busy
  input  llq_pkg::ctxt_t        wr_ctxt,
  input  llq_pkg::queue_state_t wr_state,
  output llq_pkg::queue_state_t rd_state,   // One edge after rd_en
  output logic                  busy
);

  typedef enum logic [1:0] {
    INIT_RESET,  // Counter cleared and waiting to start
    INIT_EXEC,   // One context written per cycle
    INIT_DONE    // Pipeline owns the write port
  } init_fsm_t;

  init_fsm_t             fsm_q;
  init_fsm_t             fsm_d;
  llq_pkg::ctxt_t        init_ctxt_q;  // Context being cleared
  logic                  init_wr;
  logic                  ram_wr_en;
  llq_pkg::ctxt_t        ram_wr_ctxt;
  llq_pkg::queue_state_t ram_wr_state;

  assign init_wr = (fsm_q == INIT_EXEC);
  assign busy    = (fsm_q != INIT_DONE);

  // Sequencer next state
  always_comb
  begin
    fsm_d = fsm_q;
    case (fsm_q)
      INIT_RESET: fsm_d = INIT_EXEC;
      INIT_EXEC:
      begin
        if (init_ctxt_q == llq_pkg::ctxt_t'(llq_pkg::NUM_CTXT - 1))
          fsm_d = INIT_DONE;  // Last context written
      end
      default:    fsm_d = INIT_DONE;
    endcase
  end

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      fsm_q       <= INIT_RESET;
      init_ctxt_q <= '0;
    end
    else
    begin
      fsm_q <= fsm_d;
      if (init_wr)
        init_ctxt_q <= init_ctxt_q + 1'b1;
    end
  end

  // Write port select
  always_comb
  begin
    if (init_wr)
    begin
      ram_wr_en    = 1'b1;
      ram_wr_ctxt  = init_ctxt_q;
      ram_wr_state = '{empty: 1'b1, head: '0, tail: '0};  // Empty queue
    end
    else
    begin
      ram_wr_en    = wr_en;
      ram_wr_ctxt  = wr_ctxt;
      ram_wr_state = wr_state;
    end
  end

  sync_ram #(
    .payload_t (llq_pkg::queue_state_t),
    .DEPTH     (llq_pkg::NUM_CTXT)
  ) u_state_ram (
    .clk     (clk),
    .rd_en   (rd_en),
    .rd_addr (rd_ctxt),
    .wr_en   (ram_wr_en),
    .wr_addr (ram_wr_ctxt),
    .wr_data (ram_wr_state),
    .rd_data (rd_state)
  );

  // Commands are held off until init ends
  a_no_pipe_wr_while_busy : assert property (@(posedge clk) disable iff (rst)
    wr_en |-> !busy)
    else $error("llq_state_table: pipeline write during init");

endmodule

`default_nettype wire

//--- verilog/llq_pipe.sv
// Two-stage command pipeline of the queue controller
// Hazard stall, next-state logic, link table access, lookup and empty status
`default_nettype none

module llq_pipe (
  input  logic                  clk,
  input  logic                  rst,
  // Command input
  input  logic                  cmd_valid,
  input  llq_pkg::cmd_t         cmd,
  output logic                  cmd_ready,
  // Status in
  input  logic                  busy,
  input  logic                  full,
  // Free pool
  input  llq_pkg::addr_t        alloc_addr,
  output logic                  alloc,
  output logic                  release_en,
  output llq_pkg::addr_t        release_addr,
  // State table
  input  llq_pkg::queue_state_t rd_state,
  output logic                  rd_en,
  output llq_pkg::ctxt_t        rd_ctxt,
  output logic                  wr_en,
  output llq_pkg::ctxt_t        wr_ctxt,
  output llq_pkg::queue_state_t wr_state,
  // Link table
  input  llq_pkg::addr_t        link_rd_data,
  output logic                  link_rd_en,
  output llq_pkg::addr_t        link_rd_addr,
  output logic                  link_wr_en,
  output llq_pkg::addr_t        link_wr_addr,
  output llq_pkg::addr_t        link_wr_data,
  // Lookup and status out
  output logic                  lkup_valid,
  output llq_pkg::lkup_t        lkup,
  output llq_pkg::ctxt_vec_t    empty
);

  // Command plus its entry as it travels down the pipe
  typedef struct packed {
    llq_pkg::cmd_t  cmd;
    llq_pkg::addr_t entry;  // Allocated entry of a push
  } stage_t;

  logic                  xfer;
  logic                  hazard;
  logic                  s1_valid;
  stage_t                s1_q;
  logic                  s2_valid;
  stage_t                s2_q;
  llq_pkg::queue_state_t s2_state_q;  // State read in s1
  llq_pkg::queue_state_t s2_next;
  logic                  s2_fault;
  logic                  s2_commit;   // State changes this edge

  // Stall while the same context is in s1 or s2
  assign hazard = (s1_valid && (s1_q.cmd.ctxt == cmd.ctxt))
               || (s2_valid && (s2_q.cmd.ctxt == cmd.ctxt));

  assign cmd_ready = !busy && !hazard && !(cmd.push && full);
  assign xfer      = cmd_valid && cmd_ready;

  assign alloc   = xfer && cmd.push;  // Entry taken on transfer edge
  assign rd_en   = xfer;              // State arrives in s1
  assign rd_ctxt = cmd.ctxt;

  // Stage s1 register
  always_ff @(posedge clk)
  begin
    if (rst)
      s1_valid <= 1'b0;
    else
      s1_valid <= xfer;
  end

  always_ff @(posedge clk)
  begin
    if (xfer)
    begin
      s1_q.cmd   <= cmd;
      s1_q.entry <= alloc_addr;  // Don't care on pop
    end
  end

  // s1 link table access
  // Push appends behind old tail and pop fetches successor of head
  assign link_wr_en   = s1_valid && s1_q.cmd.push && !rd_state.empty;
  assign link_wr_addr = rd_state.tail;
  assign link_wr_data = s1_q.entry;
  assign link_rd_en   = s1_valid && !s1_q.cmd.push && !rd_state.empty;
  assign link_rd_addr = rd_state.head;

  // Stage s2 register
  always_ff @(posedge clk)
  begin
    if (rst)
      s2_valid <= 1'b0;
    else
      s2_valid <= s1_valid;
  end

  always_ff @(posedge clk)
  begin
    if (s1_valid)
    begin
      s2_q       <= s1_q;
      s2_state_q <= rd_state;  // Snapshot as RAM output may move on
    end
  end

  // s2 next state
  always_comb
  begin
    s2_next  = s2_state_q;
    s2_fault = 1'b0;
    if (s2_q.cmd.push)
    begin
      s2_next.empty = 1'b0;
      s2_next.tail  = s2_q.entry;
      if (s2_state_q.empty)
        s2_next.head = s2_q.entry;  // First entry is also oldest
    end
    else if (s2_state_q.empty)
      s2_fault = 1'b1;              // Nothing to pop so state is kept
    else if (s2_state_q.head == s2_state_q.tail)
      s2_next.empty = 1'b1;         // Last entry leaves
    else
      s2_next.head = link_rd_data;  // Advance to successor
  end

  assign s2_commit = s2_valid && !s2_fault;

  // s2 write back and release
  assign wr_en        = s2_commit;
  assign wr_ctxt      = s2_q.cmd.ctxt;
  assign wr_state     = s2_next;
  assign release_en   = s2_commit && !s2_q.cmd.push;
  assign release_addr = s2_state_q.head;  // Popped entry

  // Per-context empty flags
  always_ff @(posedge clk)
  begin
    if (rst)
      empty <= '1;
    else if (s2_commit)
      empty[s2_q.cmd.ctxt] <= s2_next.empty;
  end

  // Lookup record
  always_ff @(posedge clk)
  begin
    if (rst)
      lkup_valid <= 1'b0;
    else
      lkup_valid <= s2_valid;  // One-cycle pulse per command
  end

  always_ff @(posedge clk)
  begin
    if (s2_valid)
    begin
      lkup.rnw         <= !s2_q.cmd.push;
      lkup.data        <= s2_q.cmd.push ? s2_q.cmd.data : '0;
      lkup.empty_fault <= s2_fault;
      if (s2_q.cmd.push)
        lkup.addr <= s2_q.entry;
      else if (s2_fault)
        lkup.addr <= '0;
      else
        lkup.addr <= s2_state_q.head;
    end
  end

  // Stalled command stays put at the source
  a_cmd_held : assert property (@(posedge clk) disable iff (rst)
    (cmd_valid && !cmd_ready) |=> (!cmd_valid || $stable(cmd)))
    else $error("llq_pipe: command changed while stalled");

endmodule

`default_nettype wire

//--- verilog/llq_top.sv
// Top level of the linked-list queue controller
// Pipeline, free pool, state table and link table
`default_nettype none

module llq_top (
  input  logic               clk,
  input  logic               rst,
  input  logic               cmd_valid,
  input  llq_pkg::cmd_t      cmd,
  output logic               cmd_ready,
  output logic               lkup_valid,
  output llq_pkg::lkup_t     lkup,
  output logic               full,
  output llq_pkg::ctxt_vec_t empty,
  output logic               busy
);

  // Free pool
  logic                  alloc;
  llq_pkg::addr_t        alloc_addr;
  logic                  release_en;
  llq_pkg::addr_t        release_addr;
  // State table
  logic                  st_rd_en;
  llq_pkg::ctxt_t        st_rd_ctxt;
  llq_pkg::queue_state_t st_rd_state;
  logic                  st_wr_en;
  llq_pkg::ctxt_t        st_wr_ctxt;
  llq_pkg::queue_state_t st_wr_state;
  // Link table
  logic                  link_rd_en;
  llq_pkg::addr_t        link_rd_addr;
  llq_pkg::addr_t        link_rd_data;
  logic                  link_wr_en;
  llq_pkg::addr_t        link_wr_addr;
  llq_pkg::addr_t        link_wr_data;

  llq_pipe u_pipe (
    .clk          (clk),
    .rst          (rst),
    .cmd_valid    (cmd_valid),
    .cmd          (cmd),
    .cmd_ready    (cmd_ready),
    .busy         (busy),
    .full         (full),
    .alloc_addr   (alloc_addr),
    .alloc        (alloc),
    .release_en   (release_en),
    .release_addr (release_addr),
    .rd_state     (st_rd_state),
    .rd_en        (st_rd_en),
    .rd_ctxt      (st_rd_ctxt),
    .wr_en        (st_wr_en),
    .wr_ctxt      (st_wr_ctxt),
    .wr_state     (st_wr_state),
    .link_rd_data (link_rd_data),
    .link_rd_en   (link_rd_en),
    .link_rd_addr (link_rd_addr),
    .link_wr_en   (link_wr_en),
    .link_wr_addr (link_wr_addr),
    .link_wr_data (link_wr_data),
    .lkup_valid   (lkup_valid),
    .lkup         (lkup),
    .empty        (empty)
  );

  llq_free_pool u_free_pool (
    .clk          (clk),
    .rst          (rst),
    .alloc        (alloc),
    .release_en   (release_en),
    .release_addr (release_addr),
    .alloc_addr   (alloc_addr),
    .full         (full)
  );

  llq_state_table u_state_table (
    .clk      (clk),
    .rst      (rst),
    .rd_en    (st_rd_en),
    .rd_ctxt  (st_rd_ctxt),
    .wr_en    (st_wr_en),
    .wr_ctxt  (st_wr_ctxt),
    .wr_state (st_wr_state),
    .rd_state (st_rd_state),
    .busy     (busy)
  );

  // Next-entry pointer per entry
  sync_ram #(
    .payload_t (llq_pkg::addr_t),
    .DEPTH     (llq_pkg::NUM_ENTRY)
  ) u_link_table (
    .clk     (clk),
    .rd_en   (link_rd_en),
    .rd_addr (link_rd_addr),
    .wr_en   (link_wr_en),
    .wr_addr (link_wr_addr),
    .wr_data (link_wr_data),
    .rd_data (link_rd_data)
  );

endmodule

`default_nettype wire

//--- bench/tb_clk_gen.sv
// Testbench clock and reset generator
`default_nettype none

module tb_clk_gen #(
  parameter int PERIOD     = 40,
  parameter int RST_CYCLES = 5
) (
  output logic clk,
  output logic rst
);

  initial
  begin
    clk = 1'b0;
    forever #(PERIOD / 2) clk = ~clk;
  end

  // Reset released on a rising edge
  initial
  begin
    rst = 1'b1;
    repeat (RST_CYCLES) @(posedge clk);
    rst <= 1'b0;
  end

endmodule

`default_nettype wire

//--- bench/llq_tb.sv
// Queue controller testbench with stimulus table, random phase and reference model
// Lookup monitor, value check, timeout and result message
`default_nettype none

module llq_tb;

  localparam int NUM_ROWS    = 17;
  localparam int NUM_RAND    = 40;
  localparam int NUM_CMDS    = NUM_ROWS + NUM_RAND + llq_pkg::NUM_ENTRY + 2;
  localparam int CYCLE_LIMIT = 4 * NUM_CMDS + llq_pkg::NUM_CTXT + 50;

  typedef struct packed {
    logic            drain;  // Wait for an idle pipe first
    logic            push;
    llq_pkg::ctxt_t  ctxt;
    llq_pkg::data_t  data;
    logic            rnw;    // Expected record from here on
    llq_pkg::addr_t  addr;
    logic            fault;
  } row_t;

  typedef struct packed {
    llq_pkg::lkup_t     rec;
    llq_pkg::ctxt_vec_t empty;  // Empty vector once the command is done
    int                 due;    // Cycle of the lookup pulse
  } exp_rec_t;

  logic               clk;
  logic               rst;
  logic               cmd_valid;
  llq_pkg::cmd_t      cmd;
  logic               cmd_ready;
  logic               lkup_valid;
  llq_pkg::lkup_t     lkup;
  logic               full;
  llq_pkg::ctxt_vec_t empty;
  logic               busy;

  row_t     stim_tbl [NUM_ROWS];
  exp_rec_t exp_q [$];      // Pending lookups in acceptance order
  exp_rec_t mon_exp;
  int       cycle_cnt = 0;
  integer   seed;

  // Reference model state
  logic [llq_pkg::NUM_ENTRY-1:0] pool_used;
  llq_pkg::addr_t fifo_mem [llq_pkg::NUM_CTXT][llq_pkg::NUM_ENTRY];
  int             fifo_rd  [llq_pkg::NUM_CTXT];
  int             fifo_cnt [llq_pkg::NUM_CTXT];
  int             rel_edge_q [$];  // Edge from which a freed entry is visible
  llq_pkg::addr_t rel_addr_q [$];

  tb_clk_gen #(.PERIOD(40), .RST_CYCLES(5)) u_clk_gen (.clk(clk), .rst(rst));

  llq_top u_dut (
    .clk        (clk),
    .rst        (rst),
    .cmd_valid  (cmd_valid),
    .cmd        (cmd),
    .cmd_ready  (cmd_ready),
    .lkup_valid (lkup_valid),
    .lkup       (lkup),
    .full       (full),
    .empty      (empty),
    .busy       (busy)
  );

  task automatic abort_run(input string msg);
    $display("%s", msg);
    $display("Some tests failed");
    $fatal(1);
  endtask

  task automatic check_value(input string name, input logic [63:0] got, input logic [63:0] exp);
    if (got !== exp)
      abort_run($sformatf("CHECK FAILED at %0t: %s is 0x%0h, expected 0x%0h",
                          $time, name, got, exp));
  endtask

  // Lowest free entry on push and oldest entry on pop
  task automatic load_table();
    stim_tbl[0]  = '{1'b0, 1'b1, 3'd0, 16'h1000, 1'b0, 5'd0, 1'b0};
    stim_tbl[1]  = '{1'b0, 1'b1, 3'd1, 16'h1001, 1'b0, 5'd1, 1'b0};
    stim_tbl[2]  = '{1'b0, 1'b1, 3'd2, 16'h1002, 1'b0, 5'd2, 1'b0};
    stim_tbl[3]  = '{1'b0, 1'b1, 3'd0, 16'h1003, 1'b0, 5'd3, 1'b0};
    stim_tbl[4]  = '{1'b0, 1'b1, 3'd3, 16'h1004, 1'b0, 5'd4, 1'b0};
    stim_tbl[5]  = '{1'b0, 1'b1, 3'd1, 16'h1005, 1'b0, 5'd5, 1'b0};
    stim_tbl[6]  = '{1'b0, 1'b1, 3'd0, 16'h1006, 1'b0, 5'd6, 1'b0};
    stim_tbl[7]  = '{1'b0, 1'b0, 3'd0, 16'hdead, 1'b1, 5'd0, 1'b0};  // Oldest of ctxt 0
    stim_tbl[8]  = '{1'b0, 1'b0, 3'd1, 16'hdead, 1'b1, 5'd1, 1'b0};
    stim_tbl[9]  = '{1'b0, 1'b0, 3'd0, 16'hdead, 1'b1, 5'd3, 1'b0};  // Stalls on ctxt 0
    stim_tbl[10] = '{1'b0, 1'b0, 3'd2, 16'hdead, 1'b1, 5'd2, 1'b0};  // ctxt 2 empties
    stim_tbl[11] = '{1'b0, 1'b0, 3'd0, 16'hdead, 1'b1, 5'd6, 1'b0};
    stim_tbl[12] = '{1'b0, 1'b0, 3'd2, 16'hbeef, 1'b1, 5'd0, 1'b1};  // Pop of empty queue
    stim_tbl[13] = '{1'b1, 1'b1, 3'd2, 16'h2000, 1'b0, 5'd0, 1'b0};  // Reuse lowest freed
    stim_tbl[14] = '{1'b0, 1'b1, 3'd5, 16'h2001, 1'b0, 5'd1, 1'b0};
    stim_tbl[15] = '{1'b0, 1'b0, 3'd2, 16'hdead, 1'b1, 5'd0, 1'b0};
    stim_tbl[16] = '{1'b0, 1'b0, 3'd1, 16'hdead, 1'b1, 5'd5, 1'b0};
  endtask

  task automatic model_reset();
    pool_used = '0;
    for (int k = 0; k < llq_pkg::NUM_CTXT; k++)
    begin
      fifo_rd[k]  = 0;
      fifo_cnt[k] = 0;
    end
  endtask

  // Apply one command accepted at edge edge_no
  task automatic model_step(input llq_pkg::cmd_t c, input int edge_no,
                            output llq_pkg::lkup_t rec, output llq_pkg::ctxt_vec_t emp);
    llq_pkg::addr_t a;
    int             slot;
    logic           found;
    rec = '0;
    while (rel_edge_q.size() > 0 && rel_edge_q[0] <= edge_no)
    begin
      a            = rel_addr_q.pop_front();  // Freed entry back in pool
      rel_edge_q.delete(0);
      pool_used[a] = 1'b0;
    end
    if (c.push)
    begin
      found = 1'b0;
      a     = '0;
      for (int i = 0; i < llq_pkg::NUM_ENTRY; i++)
      begin
        if (!found && !pool_used[i])
        begin
          a     = llq_pkg::addr_t'(i);
          found = 1'b1;
        end
      end
      pool_used[a] = 1'b1;
      slot = (fifo_rd[c.ctxt] + fifo_cnt[c.ctxt]) % llq_pkg::NUM_ENTRY;
      fifo_mem[c.ctxt][slot] = a;
      fifo_cnt[c.ctxt]++;
      rec.addr = a;
      rec.data = c.data;
    end
    else if (fifo_cnt[c.ctxt] == 0)
    begin
      rec.rnw         = 1'b1;
      rec.empty_fault = 1'b1;  // Nothing changes
    end
    else
    begin
      a = fifo_mem[c.ctxt][fifo_rd[c.ctxt]];
      fifo_rd[c.ctxt] = (fifo_rd[c.ctxt] + 1) % llq_pkg::NUM_ENTRY;
      fifo_cnt[c.ctxt]--;
      rel_addr_q.push_back(a);
      rel_edge_q.push_back(edge_no + 3);  // Pool frees it at edge_no + 2
      rec.rnw  = 1'b1;
      rec.addr = a;
    end
    for (int k = 0; k < llq_pkg::NUM_CTXT; k++)
      emp[k] = (fifo_cnt[k] == 0);
  endtask

  // Starts on a rising edge and returns on the transfer edge
  task automatic send_cmd(input llq_pkg::cmd_t c, input logic use_row,
                          input llq_pkg::lkup_t row_rec);
    int                 edge_no;
    llq_pkg::lkup_t     model_rec;
    llq_pkg::ctxt_vec_t emp;
    exp_rec_t           e;
    cmd       <= c;
    cmd_valid <= 1'b1;
    @(negedge clk);
    while (!cmd_ready)
      @(negedge clk);
    edge_no = cycle_cnt + 1;  // Next rising edge transfers
    @(posedge clk);
    model_step(c, edge_no, model_rec, emp);
    e.rec   = use_row ? row_rec : model_rec;
    e.empty = emp;
    e.due   = edge_no + 2;
    exp_q.push_back(e);
  endtask

  task automatic wait_idle();
    cmd_valid <= 1'b0;
    @(negedge clk);
    while (exp_q.size() != 0)
      @(negedge clk);
    @(posedge clk);
  endtask

  task automatic check_reset_init();
    @(negedge clk);
    while (rst)
      @(negedge clk);
    check_value("busy", 64'(busy), 64'(1'b1));
    check_value("empty", 64'(empty), 64'(llq_pkg::ctxt_vec_t'('1)));
    check_value("full", 64'(full), 64'(1'b0));
    while (busy)
    begin
      check_value("cmd_ready", 64'(cmd_ready), 64'(1'b0));  // Held off during init
      check_value("lkup_valid", 64'(lkup_valid), 64'(1'b0));
      @(negedge clk);
    end
    check_value("empty", 64'(empty), 64'(llq_pkg::ctxt_vec_t'('1)));
    @(posedge clk);
  endtask

  task automatic run_table();
    llq_pkg::cmd_t  c;
    llq_pkg::lkup_t rec;
    for (int i = 0; i < NUM_ROWS; i++)
    begin
      if (stim_tbl[i].drain)
        wait_idle();
      c.push          = stim_tbl[i].push;
      c.ctxt          = stim_tbl[i].ctxt;
      c.data          = stim_tbl[i].data;
      rec.rnw         = stim_tbl[i].rnw;
      rec.addr        = stim_tbl[i].addr;
      rec.data        = stim_tbl[i].push ? stim_tbl[i].data : '0;  // Zero on pop
      rec.empty_fault = stim_tbl[i].fault;
      send_cmd(c, 1'b1, rec);
    end
    wait_idle();
  endtask

  task automatic run_random();
    llq_pkg::cmd_t c;
    logic [31:0]   r;
    for (int i = 0; i < NUM_RAND; i++)
    begin
      r      = $random(seed);
      c.push = r[0] && ($countones(pool_used) < llq_pkg::NUM_ENTRY);  // Never stuck on full
      c.ctxt = r[3:1];
      c.data = r[31:16];
      send_cmd(c, 1'b0, '0);
    end
    wait_idle();
  endtask

  // Fill the pool so a push must wait and a pop must pass
  task automatic run_fill();
    llq_pkg::cmd_t c;
    int            live;
    live = 0;
    for (int k = 0; k < llq_pkg::NUM_CTXT; k++)
      live += fifo_cnt[k];
    c.push = 1'b1;
    for (int i = 0; i < llq_pkg::NUM_ENTRY - live; i++)
    begin
      c.ctxt = llq_pkg::ctxt_t'(i % llq_pkg::NUM_CTXT);
      c.data = llq_pkg::data_t'(i) ^ 16'h5a00;
      send_cmd(c, 1'b0, '0);
    end
    wait_idle();
    cmd       <= c;  // Blocked push
    cmd_valid <= 1'b1;
    repeat (4)
    begin
      @(negedge clk);
      check_value("full", 64'(full), 64'(1'b1));
      check_value("cmd_ready", 64'(cmd_ready), 64'(1'b0));
    end
    @(posedge clk);
    cmd_valid <= 1'b0;  // Push withdrawn before the pop
    @(posedge clk);
    for (int k = llq_pkg::NUM_CTXT - 1; k >= 0; k--)
    begin
      if (fifo_cnt[k] != 0)
        c.ctxt = llq_pkg::ctxt_t'(k);  // Lowest non-empty context
    end
    c.push = 1'b0;
    send_cmd(c, 1'b0, '0);
    wait_idle();
    @(negedge clk);
    check_value("full", 64'(full), 64'(1'b0));  // Pop freed one entry
    @(posedge clk);
    c.push = 1'b1;
    send_cmd(c, 1'b0, '0);
    wait_idle();
  endtask

  // Lookup monitor for record, empty vector and latency
  always @(negedge clk)
  begin
    if (!rst && lkup_valid)
    begin
      if (exp_q.size() == 0)
        abort_run("Lookup pulse appeared with no accepted command pending");
      else
      begin
        mon_exp = exp_q.pop_front();
        check_value("lookup cycle", 64'(cycle_cnt), 64'(mon_exp.due));
        check_value("lkup.rnw", 64'(lkup.rnw), 64'(mon_exp.rec.rnw));
        check_value("lkup.addr", 64'(lkup.addr), 64'(mon_exp.rec.addr));
        check_value("lkup.data", 64'(lkup.data), 64'(mon_exp.rec.data));
        check_value("lkup.empty_fault", 64'(lkup.empty_fault), 64'(mon_exp.rec.empty_fault));
        check_value("empty", 64'(empty), 64'(mon_exp.empty));
      end
    end
    else if (!rst && exp_q.size() != 0 && cycle_cnt >= exp_q[0].due)
      abort_run("Expected lookup pulse did not appear two cycles after transfer");
  end

  // Cycle counter and timeout
  always @(posedge clk)
  begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= CYCLE_LIMIT)
      abort_run($sformatf("Timeout, run did not finish within %0d cycles", CYCLE_LIMIT));
  end

  initial
  begin
    cmd_valid = 1'b0;
    cmd       = '0;
    seed      = 32'h0aff_e6c7;
    load_table();
    model_reset();
    check_reset_init();
    run_table();
    run_random();
    run_fill();
    if (exp_q.size() != 0)
      abort_run("Lookups still pending at the end of the run");
    else
    begin
      $display("All tests passed");
      $finish;
    end
  end

endmodule

`default_nettype wire

//--- vlog.f
verilog/llq_pkg.sv
verilog/sync_ram.sv
verilog/llq_free_pool.sv
verilog/llq_state_table.sv
verilog/llq_pipe.sv
verilog/llq_top.sv
bench/tb_clk_gen.sv
bench/llq_tb.sv

//--- Makefile
.PHONY: sim clean

sim:
	verilator --binary --timing --assert -Wno-fatal -f vlog.f --top-module llq_tb -Mdir obj_dir
	./obj_dir/Vllq_tb | tee sim.log
	grep -q "All tests passed" sim.log

clean:
	rm -rf obj_dir sim.log
